/* compile.f */
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_memory.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_rv_core -f compile.f -o tb_rv_core

# the simulator exits non-zero on failure, the log decides the result
./obj_dir/tb_rv_core | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1

/* tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int          MEM_ADDR_W   = 12;
    localparam logic [31:0] UART_ADDR    = rv_pkg::UART_TX_ADDR_DEFAULT;
    localparam int          DATA_WORD0   = 32'h2000 / 4;  // x30 points here
    localparam int          DATA_WORDS   = 16;
    localparam int          N_TESTS      = 8;
    localparam int          N_RANDOM     = 60;
    localparam int          PROG_LEN     = 3 + N_RANDOM + 29 * 8 + 1;
    localparam int          RESET_CYCLES = 5;
    localparam int          RUN_CYCLES   = PROG_LEN + 40;
    localparam int          TEST_CYCLES  = PROG_LEN + DATA_WORDS + RESET_CYCLES + RUN_CYCLES + 4;
    localparam int          WATCHDOG_NS  = 2 * N_TESTS * TEST_CYCLES * 10;

    logic                  clk;
    logic                  reset;
    logic                  load_en;
    logic [MEM_ADDR_W-1:0] load_addr;
    rv_pkg::xlen_t         load_data;
    logic                  uart_en;
    rv_pkg::byte_t         uart_tx_data;

    logic [31:0]   rng;
    string         test_name;
    rv_pkg::inst_t prog [PROG_LEN];
    logic          no_target [PROG_LEN];  // marks a jalr whose auipc base must run
    int            jump_to [PROG_LEN];
    rv_pkg::xlen_t model_mem [2**MEM_ADDR_W];
    rv_pkg::xlen_t model_reg [32];
    rv_pkg::byte_t exp_bytes [$];
    int            exp_cycle [$];      // cycle after release when the strobe is due

    rv_core #(.MEM_ADDR_W(MEM_ADDR_W), .UART_TX_ADDR(UART_ADDR)) rv_core_i (
        .clk(clk), .reset(reset), .i_load_en(load_en), .i_load_addr(load_addr),
        .i_load_data(load_data), .o_uart_en(uart_en), .o_uart_tx_data(uart_tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // failure handling and compares
    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(string what, rv_pkg::byte_t exp, rv_pkg::byte_t act);
        if (act !== exp) begin
            $display("FAIL %s %s expected 0x%02h actual 0x%02h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %b actual %b", test_name, what, exp, act);
            stop_run();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the core stopped making progress");
        stop_run();
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // instruction encoders
    function automatic rv_pkg::inst_t enc_i(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
                                             logic [2:0] f3, rv_pkg::reg_idx_t rd,
                                             logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::inst_t enc_s(logic [11:0] imm, rv_pkg::reg_idx_t rs2,
                                             rv_pkg::reg_idx_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic rv_pkg::inst_t enc_b(logic [12:0] imm, rv_pkg::reg_idx_t rs2,
                                             rv_pkg::reg_idx_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t enc_j(logic [20:0] imm, rv_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // program generator
    task automatic build_program();
        int               pos;
        int               kind;
        logic [31:0]      r;
        logic [31:0]      r2;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [11:0]      imm;
        rv_pkg::reg_idx_t rd;
        rv_pkg::reg_idx_t rs1;
        rv_pkg::reg_idx_t rs2;
        rv_pkg::reg_idx_t rt;
        for (int i = 0; i < PROG_LEN; i++) begin
            no_target[i] = 1'b0;
            jump_to[i]   = -1;
        end
        prog[0] = {20'h00020, 5'd31, rv_pkg::OP_LUI};          // console address
        prog[1] = enc_i(12'h020, 5'd31, 3'b000, 5'd31, rv_pkg::OP_IMM);
        prog[2] = {20'h00002, 5'd30, rv_pkg::OP_LUI};          // data area
        pos = 3;
        while (pos < 3 + N_RANDOM) begin
            r    = next_random();
            r2   = next_random();
            rd   = rv_pkg::reg_idx_t'(1 + int'(r[4:0]) % 29);
            rs1  = rv_pkg::reg_idx_t'(int'(r[9:5]) % 30);
            rs2  = rv_pkg::reg_idx_t'(int'(r[14:10]) % 30);
            kind = int'(r[19:15]) % 9;
            f3   = r[22:20];
            f7   = r[23] ? rv_pkg::F7_ALT : 7'd0;
            imm  = r2[11:0];
            if (kind == 8 && pos + 2 > 3 + N_RANDOM) kind = 1;
            case (kind)
                0: begin
                    if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'd0;
                    prog[pos] = {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
                end
                1: begin
                    if (f3 == 3'b001) imm = {7'd0, imm[4:0]};
                    else if (f3 == 3'b101) imm = {f7, imm[4:0]};  // srli or srai
                    prog[pos] = enc_i(imm, rs1, f3, rd, rv_pkg::OP_IMM);
                end
                2: prog[pos] = {r2[31:12], rd, rv_pkg::OP_LUI};
                3: prog[pos] = {r2[31:12], rd, rv_pkg::OP_AUIPC};
                4: begin
                    if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
                    imm = {6'd0, r2[5:0]} & ~((12'd1 << f3[1:0]) - 12'd1);  // aligned
                    prog[pos] = enc_i(imm, 5'd30, f3, rd, rv_pkg::OP_LOAD);
                end
                5: begin
                    f3 = {1'b0, r[21:20]};
                    if (f3 == 3'b011) f3 = 3'b000;
                    imm = {6'd0, r2[5:0]} & ~((12'd1 << f3[1:0]) - 12'd1);
                    prog[pos] = enc_s(imm, rs2, 5'd30, f3);
                end
                6: begin
                    if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                    prog[pos]    = enc_b(13'(4 + 4 * int'(r2[1:0])), rs2, rs1, f3);
                    jump_to[pos] = pos + 1 + int'(r2[1:0]);
                end
                7: begin
                    prog[pos]    = enc_j(21'(4 + 4 * int'(r2[1:0])), rd);
                    jump_to[pos] = pos + 1 + int'(r2[1:0]);
                end
                default: begin
                    rt = rv_pkg::reg_idx_t'(1 + int'(r2[20:16]) % 29);
                    prog[pos]     = {20'd0, rt, rv_pkg::OP_AUIPC};
                    prog[pos + 1] = enc_i(12'(8 + 4 * int'(r2[1:0]) + int'(r2[2])), rt,
                                          3'b000, rd, rv_pkg::OP_JALR);  // bit 0 may be set
                    jump_to[pos]  = pos + 2 + int'(r2[1:0]);
                    no_target[pos + 1] = 1'b1;
                    pos++;
                end
            endcase
            pos++;
        end
        // no jump may land between an auipc and its jalr
        for (int i = 3; i < 3 + N_RANDOM; i++) begin
            if (jump_to[i] >= 0 && no_target[jump_to[i]]) begin
                prog[i] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, rv_pkg::OP_IMM);
                if (no_target[i + 1]) begin  // jalr whose auipc base is gone
                    prog[i + 1] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, rv_pkg::OP_IMM);
                end
            end
        end
        for (int reg_n = 1; reg_n < 30; reg_n++) begin
            for (int b = 0; b < 4; b++) begin
                prog[pos]     = enc_s(12'd0, rv_pkg::reg_idx_t'(reg_n), 5'd31, 3'b000);
                prog[pos + 1] = enc_i(12'd8, rv_pkg::reg_idx_t'(reg_n), 3'b101,
                                      rv_pkg::reg_idx_t'(reg_n), rv_pkg::OP_IMM);
                pos += 2;
            end
        end
        prog[pos] = enc_j(21'd0, 5'd0);  // park
    endtask

    //////////////////////////////////////////////////////////////////////
    // instruction-set model
    function automatic rv_pkg::xlen_t alu_value(logic [2:0] f3, logic alt, logic is_imm,
                                                rv_pkg::xlen_t a, rv_pkg::xlen_t b);
        rv_pkg::xlen_t v;
        case (f3)
            3'b000: v = (alt && !is_imm) ? a - b : a + b;
            3'b001: v = a << b[4:0];
            3'b010: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: v = (a < b) ? 32'd1 : 32'd0;
            3'b100: v = a ^ b;
            3'b101: begin
                if (alt) v = $signed(a) >>> b[4:0];
                else v = a >> b[4:0];
            end
            3'b110: v = a | b;
            default: v = a & b;
        endcase
        return v;
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, rv_pkg::xlen_t a, rv_pkg::xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic rv_pkg::xlen_t load_value(logic [2:0] f3, rv_pkg::xlen_t word,
                                                 logic [1:0] off);
        rv_pkg::byte_t bv;
        logic [15:0]   hv;
        bv = word[8 * int'(off) +: 8];
        hv = off[1] ? word[31:16] : word[15:0];
        case (f3)
            3'b000:  return {{24{bv[7]}}, bv};
            3'b001:  return {{16{hv[15]}}, hv};
            3'b100:  return {24'd0, bv};
            3'b101:  return {16'd0, hv};
            default: return word;
        endcase
    endfunction

    task automatic model_run(int steps);
        rv_pkg::xlen_t pc;
        rv_pkg::xlen_t npc;
        rv_pkg::inst_t ins;
        rv_pkg::xlen_t a;
        rv_pkg::xlen_t b;
        rv_pkg::xlen_t ea;
        rv_pkg::xlen_t res;
        rv_pkg::xlen_t word;
        rv_pkg::xlen_t imm_i;
        rv_pkg::xlen_t imm_s;
        rv_pkg::xlen_t imm_b;
        rv_pkg::xlen_t imm_j;
        logic [2:0]    f3;
        logic          wr;
        pc = '0;
        for (int n = 0; n < steps; n++) begin
            ins   = model_mem[pc[MEM_ADDR_W+1:2]];
            f3    = ins[14:12];
            a     = model_reg[ins[19:15]];
            b     = model_reg[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc   = pc + 32'd4;
            res   = '0;
            wr    = 1'b1;
            case (ins[6:0])
                rv_pkg::OP_LUI:   res = {ins[31:12], 12'd0};
                rv_pkg::OP_AUIPC: res = pc + {ins[31:12], 12'd0};
                rv_pkg::OP_JAL: begin
                    res = pc + 32'd4;
                    npc = pc + imm_j;
                end
                rv_pkg::OP_JALR: begin
                    res = pc + 32'd4;
                    npc = (a + imm_i) & ~32'd1;
                end
                rv_pkg::OP_BRANCH: begin
                    wr = 1'b0;
                    if (branch_taken(f3, a, b)) npc = pc + imm_b;
                end
                rv_pkg::OP_LOAD: begin
                    ea  = a + imm_i;
                    res = load_value(f3, model_mem[ea[MEM_ADDR_W+1:2]], ea[1:0]);
                end
                rv_pkg::OP_STORE: begin
                    wr = 1'b0;
                    ea = a + imm_s;
                    if (ea == UART_ADDR) begin
                        exp_bytes.push_back(b[7:0]);
                        exp_cycle.push_back(n + 1);  // registered strobe
                    end else begin
                        word = model_mem[ea[MEM_ADDR_W+1:2]];
                        case (f3)
                            3'b000:  word[8 * int'(ea[1:0]) +: 8] = b[7:0];
                            3'b001:  word[16 * int'(ea[1]) +: 16] = b[15:0];
                            default: word = b;
                        endcase
                        model_mem[ea[MEM_ADDR_W+1:2]] = word;
                    end
                end
                rv_pkg::OP_IMM: res = alu_value(f3, ins[30], 1'b1, a, imm_i);
                rv_pkg::OP_REG: res = alu_value(f3, ins[30], 1'b0, a, b);
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) model_reg[ins[11:7]] = res;
            pc = npc;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one test loads under reset, runs and watches the console
    task automatic run_test(int t);
        int word_idx;
        test_name = $sformatf("test_%0d", t);
        build_program();
        exp_bytes.delete();
        exp_cycle.delete();
        for (int i = 0; i < 32; i++) model_reg[i] = '0;
        for (int i = 0; i < PROG_LEN; i++) model_mem[i] = prog[i];
        for (int i = 0; i < DATA_WORDS; i++) model_mem[DATA_WORD0 + i] = next_random();
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < PROG_LEN + DATA_WORDS; i++) begin
            word_idx  = (i < PROG_LEN) ? i : DATA_WORD0 + i - PROG_LEN;
            load_en   <= 1'b1;
            load_addr <= MEM_ADDR_W'(word_idx);
            load_data <= model_mem[word_idx];
            @(posedge clk);
        end
        load_en <= 1'b0;
        model_run(RUN_CYCLES);  // image already in the DUT
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_bit("strobe during reset", 1'b0, uart_en);
            @(posedge clk);
        end
        reset <= 1'b0;
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(negedge clk);
            if (exp_cycle.size() > 0 && exp_cycle[0] == cycle) begin
                check_bit("console strobe", 1'b1, uart_en);
                check_byte("console byte", exp_bytes.pop_front(), uart_tx_data);
                void'(exp_cycle.pop_front());
            end else begin
                check_bit("console strobe", 1'b0, uart_en);
            end
        end
        if (exp_bytes.size() != 0) begin
            $display("%s ended with %0d console bytes never sent", test_name, exp_bytes.size());
            stop_run();
        end
    endtask

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng       = 32'd49359;
        test_name = "setup";
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter int          MEM_ADDR_W   = 12,
    parameter logic [31:0] UART_TX_ADDR = rv_pkg::UART_TX_ADDR_DEFAULT
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_load_en,
    input  wire [MEM_ADDR_W-1:0]  i_load_addr,
    input  rv_pkg::xlen_t         i_load_data,
    output logic                  o_uart_en,
    output rv_pkg::byte_t         o_uart_tx_data
);

    rv_pkg::xlen_t       pc;
    rv_pkg::xlen_t       next_pc;
    rv_pkg::inst_t       inst;
    rv_pkg::reg_idx_t    rs1;
    rv_pkg::reg_idx_t    rs2;
    rv_pkg::reg_idx_t    rd;
    rv_pkg::xlen_t       imm;
    rv_pkg::inst_class_t cls;
    rv_pkg::alu_op_t     alu_op;
    logic [2:0]          funct3;
    logic                use_imm;
    rv_pkg::xlen_t       rs1_data;
    rv_pkg::xlen_t       rs2_data;
    rv_pkg::xlen_t       result;
    rv_pkg::xlen_t       addr;
    logic [MEM_ADDR_W-1:0] mem_addr;
    rv_pkg::byte_en_t    mem_be;
    rv_pkg::xlen_t       mem_wdata;
    rv_pkg::xlen_t       mem_rdata;
    logic                reg_we;
    rv_pkg::xlen_t       reg_wdata;
    logic                uart_req;
    rv_pkg::byte_t       uart_byte;

    //////////////////////////////////////////////////////////////////////
    // pc and console registers
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            o_uart_en <= 1'b0;
        end else begin
            pc        <= next_pc;
            o_uart_en <= uart_req;  // one cycle per sb to the console
        end
    end

    always_ff @(posedge clk) begin
        o_uart_tx_data <= uart_byte;
    end

    //////////////////////////////////////////////////////////////////////
    // single cycle datapath
    rv_memory #(.MEM_ADDR_W(MEM_ADDR_W)) rv_memory_i (
        .clk(clk), .i_fetch_addr(pc), .i_addr(mem_addr), .i_be(mem_be),
        .i_wdata(mem_wdata), .i_load_en(i_load_en), .i_load_addr(i_load_addr),
        .i_load_data(i_load_data), .o_inst(inst), .o_rdata(mem_rdata)
    );

    rv_decode rv_decode_i (
        .i_inst(inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_class(cls), .o_alu_op(alu_op), .o_funct3(funct3), .o_use_imm(use_imm)
    );

    rv_regfile rv_regfile_i (
        .clk(clk), .reset(reset), .i_rs1(rs1), .i_rs2(rs2), .i_we(reg_we),
        .i_rd(rd), .i_wdata(reg_wdata), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv_execute rv_execute_i (
        .i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
        .i_class(cls), .i_alu_op(alu_op), .i_funct3(funct3), .i_use_imm(use_imm),
        .o_result(result), .o_addr(addr), .o_next_pc(next_pc)
    );

    rv_result #(.MEM_ADDR_W(MEM_ADDR_W), .UART_TX_ADDR(UART_TX_ADDR)) rv_result_i (
        .i_class(cls), .i_funct3(funct3), .i_rd(rd), .i_addr(addr),
        .i_result(result), .i_rs2_data(rs2_data), .i_mem_rdata(mem_rdata),
        .o_mem_addr(mem_addr), .o_mem_be(mem_be), .o_mem_wdata(mem_wdata),
        .o_reg_we(reg_we), .o_reg_wdata(reg_wdata),
        .o_uart_req(uart_req), .o_uart_byte(uart_byte)
    );

endmodule

`default_nettype wire

/* rv_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_memory #(
    parameter int MEM_ADDR_W = 12
) (
    input  wire                   clk,
    input  rv_pkg::xlen_t         i_fetch_addr,
    input  wire [MEM_ADDR_W-1:0]  i_addr,
    input  rv_pkg::byte_en_t      i_be,
    input  rv_pkg::xlen_t         i_wdata,
    input  wire                   i_load_en,
    input  wire [MEM_ADDR_W-1:0]  i_load_addr,
    input  rv_pkg::xlen_t         i_load_data,
    output rv_pkg::inst_t         o_inst,
    output rv_pkg::xlen_t         o_rdata
);

    rv_pkg::xlen_t mem [2**MEM_ADDR_W];  // unified instruction and data

    // program load wins over the core's store
    always_ff @(posedge clk) begin
        if (i_load_en) begin
            mem[i_load_addr] <= i_load_data;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (i_be[b]) mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
            end
        end
    end

    assign o_inst  = mem[i_fetch_addr[MEM_ADDR_W+1:2]];  // word aligned fetch
    assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

/* rv_result.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_result #(
    parameter int          MEM_ADDR_W   = 12,
    parameter logic [31:0] UART_TX_ADDR = rv_pkg::UART_TX_ADDR_DEFAULT
) (
    input  rv_pkg::inst_class_t   i_class,
    input  wire [2:0]             i_funct3,
    input  rv_pkg::reg_idx_t      i_rd,
    input  rv_pkg::xlen_t         i_addr,
    input  rv_pkg::xlen_t         i_result,
    input  rv_pkg::xlen_t         i_rs2_data,
    input  rv_pkg::xlen_t         i_mem_rdata,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    output rv_pkg::byte_en_t      o_mem_be,
    output rv_pkg::xlen_t         o_mem_wdata,
    output logic                  o_reg_we,
    output rv_pkg::xlen_t         o_reg_wdata,
    output logic                  o_uart_req,
    output rv_pkg::byte_t         o_uart_byte
);

    logic             is_load;
    logic             is_store;
    logic             uart_hit;
    rv_pkg::xlen_t    lane;       // addressed bytes moved down to bit 0
    rv_pkg::xlen_t    load_data;
    rv_pkg::byte_en_t store_be;

    assign is_load    = (i_class == rv_pkg::CLS_LOAD);
    assign is_store   = (i_class == rv_pkg::CLS_STORE);
    assign uart_hit   = is_store && (i_addr == UART_TX_ADDR);
    assign o_mem_addr = i_addr[MEM_ADDR_W+1:2];

    //////////////////////////////////////////////////////////////////////
    // load extraction
    assign lane = i_mem_rdata >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};    // lb
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};  // lh
            3'b100:  load_data = {24'd0, lane[7:0]};            // lbu
            3'b101:  load_data = {16'd0, lane[15:0]};           // lhu
            default: load_data = i_mem_rdata;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // store lanes, memory merges the enabled bytes
    always_comb begin
        case (i_funct3)
            3'b000: begin
                store_be    = 4'b0001 << i_addr[1:0];
                o_mem_wdata = {4{i_rs2_data[7:0]}};
            end
            3'b001: begin
                store_be    = 4'b0011 << {i_addr[1], 1'b0};
                o_mem_wdata = {2{i_rs2_data[15:0]}};
            end
            default: begin
                store_be    = 4'b1111;
                o_mem_wdata = i_rs2_data;
            end
        endcase
    end

    assign o_mem_be    = (is_store && !uart_hit) ? store_be : 4'b0000;
    assign o_uart_req  = uart_hit && (i_funct3 == 3'b000);  // sb only
    assign o_uart_byte = i_rs2_data[7:0];

    // write-back
    always_comb begin
        case (i_class)
            rv_pkg::CLS_ALU, rv_pkg::CLS_LOAD, rv_pkg::CLS_JAL,
            rv_pkg::CLS_JALR, rv_pkg::CLS_LUI, rv_pkg::CLS_AUIPC:
                o_reg_we = (i_rd != 5'd0);
            default:
                o_reg_we = 1'b0;
        endcase
    end

    assign o_reg_wdata = is_load ? load_data : i_result;

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    input  rv_pkg::xlen_t       i_pc,
    input  rv_pkg::xlen_t       i_rs1_data,
    input  rv_pkg::xlen_t       i_rs2_data,
    input  rv_pkg::xlen_t       i_imm,
    input  rv_pkg::inst_class_t i_class,
    input  rv_pkg::alu_op_t     i_alu_op,
    input  wire [2:0]           i_funct3,
    input  wire                 i_use_imm,
    output rv_pkg::xlen_t       o_result,
    output rv_pkg::xlen_t       o_addr,
    output rv_pkg::xlen_t       o_next_pc
);

    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_out;
    rv_pkg::xlen_t pc_plus4;
    logic          taken;

    assign op_b     = i_use_imm ? i_imm : i_rs2_data;
    assign pc_plus4 = i_pc + 32'd4;
    assign o_addr   = i_rs1_data + i_imm;  // load, store and jalr base

    //////////////////////////////////////////////////////////////////////
    // alu
    always_comb begin
        case (i_alu_op)
            rv_pkg::ALU_SUB:  alu_out = i_rs1_data - op_b;
            rv_pkg::ALU_AND:  alu_out = i_rs1_data & op_b;
            rv_pkg::ALU_OR:   alu_out = i_rs1_data | op_b;
            rv_pkg::ALU_XOR:  alu_out = i_rs1_data ^ op_b;
            rv_pkg::ALU_SLL:  alu_out = i_rs1_data << op_b[4:0];
            rv_pkg::ALU_SRL:  alu_out = i_rs1_data >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_out = $signed(i_rs1_data) >>> op_b[4:0];
            rv_pkg::ALU_SLT:  alu_out = {31'd0, $signed(i_rs1_data) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_out = {31'd0, i_rs1_data < op_b};
            default:          alu_out = i_rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (i_class)
            rv_pkg::CLS_JAL,
            rv_pkg::CLS_JALR:  o_result = pc_plus4;  // link value
            rv_pkg::CLS_LUI:   o_result = i_imm;
            rv_pkg::CLS_AUIPC: o_result = i_pc + i_imm;
            default:           o_result = alu_out;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch compare and next pc
    always_comb begin
        case (i_funct3)
            3'b000:  taken = (i_rs1_data == i_rs2_data);
            3'b001:  taken = (i_rs1_data != i_rs2_data);
            3'b100:  taken = $signed(i_rs1_data) < $signed(i_rs2_data);
            3'b101:  taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
            3'b110:  taken = i_rs1_data < i_rs2_data;
            default: taken = i_rs1_data >= i_rs2_data;  // bgeu
        endcase
    end

    always_comb begin
        o_next_pc = pc_plus4;
        if (i_class == rv_pkg::CLS_JAL || (i_class == rv_pkg::CLS_BRANCH && taken)) begin
            o_next_pc = i_pc + i_imm;
        end else if (i_class == rv_pkg::CLS_JALR) begin
            o_next_pc = {o_addr[31:1], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  wire               clk,
    input  wire               reset,
    input  rv_pkg::reg_idx_t  i_rs1,
    input  rv_pkg::reg_idx_t  i_rs2,
    input  wire               i_we,
    input  rv_pkg::reg_idx_t  i_rd,
    input  rv_pkg::xlen_t     i_wdata,
    output rv_pkg::xlen_t     o_rs1_data,
    output rv_pkg::xlen_t     o_rs2_data
);

    rv_pkg::xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != 5'd0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
    input  rv_pkg::inst_t       i_inst,
    output rv_pkg::reg_idx_t    o_rs1,
    output rv_pkg::reg_idx_t    o_rs2,
    output rv_pkg::reg_idx_t    o_rd,
    output rv_pkg::xlen_t       o_imm,
    output rv_pkg::inst_class_t o_class,
    output rv_pkg::alu_op_t     o_alu_op,
    output logic [2:0]          o_funct3,
    output logic                o_use_imm
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       alt;     // funct7 selects sub or sra
    logic       is_reg;
    logic       alu_ok;  // funct7 legal for this funct3

    rv_pkg::xlen_t imm_i;
    rv_pkg::xlen_t imm_s;
    rv_pkg::xlen_t imm_b;
    rv_pkg::xlen_t imm_u;
    rv_pkg::xlen_t imm_j;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign alt    = (funct7 == rv_pkg::F7_ALT);
    assign is_reg = (opcode == rv_pkg::OP_REG);

    assign o_rd     = i_inst[11:7];
    assign o_rs1    = i_inst[19:15];
    assign o_rs2    = i_inst[24:20];
    assign o_funct3 = funct3;

    // immediate formats
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    //////////////////////////////////////////////////////////////////////
    // alu operation, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  o_alu_op = (is_reg && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  o_alu_op = rv_pkg::ALU_SLL;
            3'b010:  o_alu_op = rv_pkg::ALU_SLT;
            3'b011:  o_alu_op = rv_pkg::ALU_SLTU;
            3'b100:  o_alu_op = rv_pkg::ALU_XOR;
            3'b101:  o_alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  o_alu_op = rv_pkg::ALU_OR;
            default: o_alu_op = rv_pkg::ALU_AND;
        endcase
        // immediate forms only check funct7 on shifts
        alu_ok = 1'b1;
        if (is_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
            alu_ok = (funct7 == 7'd0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // class and immediate select
    always_comb begin
        o_class   = rv_pkg::CLS_NOP;  // anything unrecognised
        o_imm     = imm_i;
        o_use_imm = 1'b0;
        case (opcode)
            rv_pkg::OP_LUI: begin
                o_class = rv_pkg::CLS_LUI;
                o_imm   = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                o_class = rv_pkg::CLS_AUIPC;
                o_imm   = imm_u;
            end
            rv_pkg::OP_JAL: begin
                o_class = rv_pkg::CLS_JAL;
                o_imm   = imm_j;
            end
            rv_pkg::OP_JALR: begin
                if (funct3 == 3'b000) o_class = rv_pkg::CLS_JALR;
            end
            rv_pkg::OP_BRANCH: begin
                o_imm = imm_b;
                if (funct3[2:1] != 2'b01) o_class = rv_pkg::CLS_BRANCH;
            end
            rv_pkg::OP_LOAD: begin
                if (funct3 != 3'b011 && funct3[2:1] != 2'b11) o_class = rv_pkg::CLS_LOAD;
            end
            rv_pkg::OP_STORE: begin
                o_imm = imm_s;
                if (funct3 <= 3'b010) o_class = rv_pkg::CLS_STORE;
            end
            rv_pkg::OP_IMM: begin
                o_use_imm = 1'b1;
                if (alu_ok) o_class = rv_pkg::CLS_ALU;
            end
            rv_pkg::OP_REG: begin
                if (alu_ok) o_class = rv_pkg::CLS_ALU;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  inst_class_t;

    //////////////////////////////////////////////////////////////////////
    // opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra, srai

    //////////////////////////////////////////////////////////////////////
    // alu operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;

    //////////////////////////////////////////////////////////////////////
    // instruction classes
    localparam inst_class_t CLS_NOP    = 4'd0;
    localparam inst_class_t CLS_ALU    = 4'd1;
    localparam inst_class_t CLS_LOAD   = 4'd2;
    localparam inst_class_t CLS_STORE  = 4'd3;
    localparam inst_class_t CLS_BRANCH = 4'd4;
    localparam inst_class_t CLS_JAL    = 4'd5;
    localparam inst_class_t CLS_JALR   = 4'd6;
    localparam inst_class_t CLS_LUI    = 4'd7;
    localparam inst_class_t CLS_AUIPC  = 4'd8;

    localparam logic [31:0] UART_TX_ADDR_DEFAULT = 32'h0002_0020;

endpackage

`default_nettype wire
